// File: flist.f
+incdir+include
logic/mipsCtrlPkg.sv
logic/instrClassifier.sv
logic/controlSequencer.sv
logic/datapathControl.sv
logic/memoryControl.sv
logic/branchResolver.sv
logic/mipsControlUnit.sv
dv/mipsControlUnit_assert.sv
dv/mipsControlUnitTb.sv

// File: dv/mipsControlUnitTb.sv
`timescale 1ns/1ps
`include "mipsCtrl_macros.svh"

module mipsControlUnitTb import mipsCtrlPkg::*; ();

  localparam int WAIT_LIMIT = 20;

  // Instruction table, index order is
  // ADDU AND OR JR ADDIU ANDI ORI XORI SLTI LUI LW LH LHU LB LBU SW
  // BEQ BNE BLEZ BGTZ BLTZ BGEZ J JAL
  localparam logic [5:0] OPCODES [24] = '{
    6'h00, 6'h00, 6'h00, 6'h00, 6'h09, 6'h0c, 6'h0d, 6'h0e, 6'h0a, 6'h0f,
    6'h23, 6'h21, 6'h25, 6'h20, 6'h24, 6'h2b, 6'h04, 6'h05, 6'h06, 6'h07,
    6'h01, 6'h01, 6'h02, 6'h03
  };
  localparam logic [5:0] FUNCTS [4] = '{6'h21, 6'h24, 6'h25, 6'h08};

  logic clk;
  logic rst;
  logic [`MIPS_INSTR_W-1:0] instr;
  logic start;
  logic waitRequest;
  logic aluStall;
  logic aluLsb;
  logic lessThan;
  logic pcIsZero;
  logic irWrite;
  logic irSel;
  logic pcWrite;
  logic pcSrc;
  logic isJump;
  logic aluSrcA;
  logic [1:0] aluSrcB;
  aluOp_t aluControl;
  logic aluSel;
  logic extSel;
  logic regWrite;
  logic regDst;
  logic memToReg;
  logic memRead;
  logic memWrite;
  logic iOrD;
  logic [`MIPS_BYTEEN_W-1:0] byteEnable;
  logic [1:0] extendedMem;
  logic active;
  logic branchDelay;
  state_t stateCode;

  logic [31:0] lfsrState;
  int valueErrors;
  int otherErrors;

  mipsControlUnit DUT (.*);

  always #2 clk = ~clk;

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] randBits(input int width);
    logic [31:0] value;
    logic fb;
    int i;
    value = '0;
    for (i = 0; i < width; i++) begin
      fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
      lfsrState = {lfsrState[30:0], fb};
      value = {value[30:0], fb};
    end
    return value;
  endfunction

  // Random rs, rt and immediate under a fixed opcode
  function automatic logic [31:0] buildInstr(input int idx);
    logic [31:0] word;
    word = randBits(26);
    word[31:26] = OPCODES[idx];
    if (idx < 4)
      word[10:0] = {5'd0, FUNCTS[idx]};
    if (idx == 20 || idx == 21)
      word[20:16] = (idx == 21) ? 5'd1 : 5'd0;
    return word;
  endfunction

  function automatic instrClass_t expectClass(input int idx);
    if (idx <= 2) return CLS_RALU;
    if (idx == 3) return CLS_JR;
    if (idx <= 8) return CLS_IMM;
    if (idx == 9) return CLS_LUI;
    if (idx <= 14) return CLS_LOAD;
    if (idx == 15) return CLS_STORE;
    if (idx <= 21) return CLS_BRANCH;
    if (idx == 22) return CLS_J;
    return CLS_JAL;
  endfunction

  function automatic int expectCycles(input instrClass_t cls);
    case (cls)
      CLS_LOAD: return 3;
      CLS_RALU, CLS_IMM, CLS_LUI, CLS_STORE, CLS_JAL: return 2;
      default: return 1;
    endcase
  endfunction

  function automatic aluOp_t expectAluOp(input int idx);
    case (idx)
      0, 1, 2: return ALU_RFUNCT;
      5: return ALU_AND;
      6: return ALU_OR;
      7: return ALU_XOR;
      8: return ALU_SLT;
      9: return ALU_LUI;
      default: return ALU_ADD;
    endcase
  endfunction

  // Branch outcome from the current flag inputs
  function automatic logic expectTaken(input int idx);
    case (idx)
      16, 18: return aluLsb;
      17, 19: return !aluLsb;
      20: return lessThan;
      21: return !lessThan;
      3, 22, 23: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  function automatic state_t seqState(input int cyc);
    case (cyc)
      1: return DECODE;
      2: return EXEC1;
      3: return EXEC2;
      default: return EXEC3;
    endcase
  endfunction

  task automatic nextCycle();
    @(negedge clk);
  endtask

  task automatic expectEqual(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      valueErrors++;
      $display("** Error: %s = 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic waitState(input state_t target);
    int count;
    count = 0;
    while (stateCode !== target && count < WAIT_LIMIT) begin
      nextCycle();
      count++;
    end
    assert (stateCode === target) else begin
      otherErrors++;
      $display("Timed out waiting for state %s at %0t", target.name(), $time);
    end
  endtask

  // Halt through pcIsZero, then start again into FETCH
  task automatic restart();
    waitRequest = 1'b0;
    aluStall = 1'b0;
    pcIsZero = 1'b1;
    waitState(HALTED);
    pcIsZero = 1'b0;
    start = 1'b1;
    nextCycle();
    start = 1'b0;
    expectEqual("stateCode", stateCode, FETCH);
  endtask

  task automatic checkMemory(input int idx, input state_t st);
    instrClass_t cls;
    logic loadData;
    logic [3:0] expBe;
    logic [1:0] expExt;
    cls = expectClass(idx);
    loadData = (cls == CLS_LOAD) && (st == EXEC2 || st == EXEC3);
    expBe = 4'hF;
    expExt = 2'b00;
    if (loadData && (idx == 11 || idx == 12))
      expBe = 4'h3;
    if (loadData && (idx == 13 || idx == 14))
      expBe = 4'h1;
    if (loadData && idx == 11)
      expExt = 2'b11;
    if (loadData && idx == 13)
      expExt = 2'b10;
    expectEqual("memRead", memRead,
                st == FETCH || st == STALL || (cls == CLS_LOAD && st == EXEC2));
    expectEqual("memWrite", memWrite, cls == CLS_STORE && st == EXEC2);
    expectEqual("iOrD", iOrD, (cls == CLS_LOAD || cls == CLS_STORE) && st == EXEC2);
    expectEqual("byteEnable", byteEnable, expBe);
    expectEqual("extendedMem", extendedMem, expExt);
  endtask

  task automatic checkAluRegs(input int idx, input state_t st);
    instrClass_t cls;
    cls = expectClass(idx);
    if (cls == CLS_RALU || cls == CLS_IMM || cls == CLS_LUI) begin
      if (st == EXEC1) begin
        expectEqual("aluSrcA", aluSrcA, 1);
        expectEqual("aluSrcB", aluSrcB, (cls == CLS_RALU) ? 2'b00 : 2'b10);
        expectEqual("aluControl", aluControl, expectAluOp(idx));
        // ANDI, ORI and XORI zero extend
        expectEqual("extSel", extSel, idx >= 5 && idx <= 7);
        expectEqual("regWrite", regWrite, 0);
        expectEqual("regDst", regDst, 0);
        expectEqual("memToReg", memToReg, 0);
      end else if (st == EXEC2) begin
        expectEqual("aluSrcA", aluSrcA, 0);
        expectEqual("aluSrcB", aluSrcB, 0);
        expectEqual("extSel", extSel, 0);
        expectEqual("aluSel", aluSel, 1);
        expectEqual("regWrite", regWrite, 1);
        expectEqual("regDst", regDst, cls == CLS_RALU);
        expectEqual("memToReg", memToReg, 1);
      end
    end
  endtask

  // Starts and ends at a FETCH falling edge
  task automatic runInstr(input int idx, input bit detail);
    int n;
    int cyc;
    state_t exp;
    n = expectCycles(expectClass(idx));
    cyc = 0;
    expectEqual("stateCode", stateCode, FETCH);
    instr = buildInstr(idx);
    do begin
      nextCycle();
      cyc++;
      exp = (cyc >= 2 + n) ? FETCH : seqState(cyc);
      expectEqual("stateCode", stateCode, exp);
      // Instruction register loads only in DECODE
      expectEqual("irWrite", irWrite, exp == DECODE);
      expectEqual("irSel", irSel, exp != DECODE);
      if (detail) begin
        checkMemory(idx, exp);
        checkAluRegs(idx, exp);
      end
    end while (stateCode != FETCH && cyc < WAIT_LIMIT);
    assert (stateCode === FETCH) else begin
      otherErrors++;
      $display("Instruction %0d never returned to FETCH", idx);
    end
    expectEqual("cycles", cyc, 2 + n);
    expectEqual("pcSrc", pcSrc, expectTaken(idx));
  endtask

  task automatic testResetStart();
    expectEqual("stateCode", stateCode, HALTED);
    expectEqual("active", active, 0);
    expectEqual("branchDelay", branchDelay, 0);
    expectEqual("pcWrite", pcWrite, 0);
    expectEqual("pcSrc", pcSrc, 0);
    expectEqual("irWrite", irWrite, 0);
    expectEqual("isJump", isJump, 0);
    expectEqual("regWrite", regWrite, 0);
    expectEqual("memRead", memRead, 0);
    expectEqual("memWrite", memWrite, 0);
    expectEqual("iOrD", iOrD, 0);
    expectEqual("extendedMem", extendedMem, 0);
    expectEqual("byteEnable", byteEnable, 4'hF);
    start = 1'b1;
    nextCycle();
    start = 1'b0;
    expectEqual("stateCode", stateCode, FETCH);
    expectEqual("active", active, 1);
    expectEqual("pcWrite", pcWrite, 1);
    expectEqual("memRead", memRead, 1);
  endtask

  task automatic testSequencing();
    int idx;
    for (idx = 0; idx < 24; idx++)
      runInstr(idx, 1'b0);
  endtask

  task automatic testMemoryControls();
    int idx;
    restart();
    for (idx = 10; idx <= 15; idx++)
      runInstr(idx, 1'b1);
  endtask

  task automatic testAluRegControls();
    int idx;
    restart();
    for (idx = 0; idx <= 9; idx++) begin
      if (idx != 3)
        runInstr(idx, 1'b1);
    end
  endtask

  task automatic testBranches();
    int rep;
    int idx;
    int jumps[3] = '{3, 22, 23};
    logic [31:0] bits;
    restart();
    for (rep = 0; rep < 3; rep++) begin
      for (idx = 16; idx <= 21; idx++) begin
        bits = randBits(2);
        aluLsb = bits[0];
        lessThan = bits[1];
        runInstr(idx, 1'b0);
      end
    end
    foreach (jumps[j])
      runInstr(jumps[j], 1'b0);
    aluLsb = 1'b0;
    lessThan = 1'b0;
  endtask

  task automatic testWaitsHalt();
    int n;
    int k;
    state_t targets[6] = '{FETCH, DECODE, EXEC1, EXEC2, EXEC3, STALL};
    restart();
    n = 1 + int'(randBits(2));
    instr = buildInstr(0);
    waitRequest = 1'b1;
    for (k = 0; k < n; k++) begin
      nextCycle();
      expectEqual("stateCode", stateCode, STALL);
      expectEqual("memRead", memRead, 1);
    end
    waitRequest = 1'b0;
    nextCycle();
    expectEqual("stateCode", stateCode, DECODE);
    waitState(EXEC1);
    aluStall = 1'b1;
    for (k = 0; k < n; k++) begin
      nextCycle();
      expectEqual("stateCode", stateCode, EXEC1);
    end
    aluStall = 1'b0;
    nextCycle();
    expectEqual("stateCode", stateCode, EXEC2);
    waitState(FETCH);
    // Memory busy during the load data cycle
    instr = buildInstr(10);
    waitState(EXEC2);
    waitRequest = 1'b1;
    for (k = 0; k < n; k++) begin
      nextCycle();
      expectEqual("stateCode", stateCode, EXEC2);
      expectEqual("memRead", memRead, 1);
    end
    waitRequest = 1'b0;
    nextCycle();
    expectEqual("stateCode", stateCode, EXEC3);
    for (k = 0; k < 6; k++) begin
      restart();
      instr = buildInstr(10);
      waitRequest = (targets[k] == STALL);
      waitState(targets[k]);
      waitRequest = 1'b0;
      pcIsZero = 1'b1;
      nextCycle();
      pcIsZero = 1'b0;
      expectEqual("stateCode", stateCode, HALTED);
    end
  endtask

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    instr = '0;
    start = 1'b0;
    waitRequest = 1'b0;
    aluStall = 1'b0;
    aluLsb = 1'b0;
    lessThan = 1'b0;
    pcIsZero = 1'b0;
    lfsrState = 32'h74a2fd32;
    valueErrors = 0;
    otherErrors = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    testResetStart();
    testSequencing();
    testMemoryControls();
    testAluRegControls();
    testBranches();
    testWaitsHalt();
    $display("Errors: %0d value mismatches, %0d other failures", valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: dv/mipsControlUnit_assert.sv
`timescale 1ns/1ps

module mipsControlUnitAssert import mipsCtrlPkg::*; (
  input logic   clk,
  input logic   rst,
  input logic   memRead,
  input logic   memWrite,
  input logic   irWrite,
  input logic   active,
  input logic   pcIsZero,
  input state_t stateCode
);

  memExclusive: assert property (@(posedge clk) disable iff (rst) !(memRead && memWrite))
    else $error("memRead and memWrite are both high");

  irWriteDecode: assert property (@(posedge clk) disable iff (rst)
    irWrite |-> stateCode == DECODE)
    else $error("irWrite is high outside DECODE");

  // A halt request overrides the step into EXEC1
  decodeToExec: assert property (@(posedge clk) disable iff (rst)
    (stateCode == DECODE && !pcIsZero) |=> stateCode == EXEC1)
    else $error("DECODE was not followed by EXEC1");

  activeMatch: assert property (@(posedge clk) disable iff (rst)
    active == (stateCode != HALTED))
    else $error("active does not match the HALTED state");

endmodule

bind mipsControlUnit mipsControlUnitAssert uAssert (
  .clk(clk), .rst(rst), .memRead(memRead), .memWrite(memWrite), .irWrite(irWrite),
  .active(active), .pcIsZero(pcIsZero), .stateCode(stateCode)
);

// File: logic/mipsControlUnit.sv
`timescale 1ns/1ps
`include "mipsCtrl_macros.svh"

module mipsControlUnit import mipsCtrlPkg::*; (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [`MIPS_INSTR_W-1:0]  instr,
  input  logic                      start,
  input  logic                      waitRequest,
  input  logic                      aluStall,
  input  logic                      aluLsb,
  input  logic                      lessThan,
  input  logic                      pcIsZero,
  output logic                      irWrite,
  output logic                      irSel,
  output logic                      pcWrite,
  output logic                      pcSrc,
  output logic                      isJump,
  output logic                      aluSrcA,
  output logic [1:0]                aluSrcB,
  output aluOp_t                    aluControl,
  output logic                      aluSel,
  output logic                      extSel,
  output logic                      regWrite,
  output logic                      regDst,
  output logic                      memToReg,
  output logic                      memRead,
  output logic                      memWrite,
  output logic                      iOrD,
  output logic [`MIPS_BYTEEN_W-1:0] byteEnable,
  output logic [1:0]                extendedMem,
  output logic                      active,
  output logic                      branchDelay,
  output state_t                    stateCode
);

  instrClass_t instrClass;
  aluOp_t      aluOp;
  branchCond_t branchCond;
  memSize_t    memSize;
  logic        signedLoad;
  logic [1:0]  execCycles;
  state_t      state;

  assign stateCode = state;

  instrClassifier uClassifier (
    .instr(instr), .instrClass(instrClass), .execCycles(execCycles),
    .aluOp(aluOp), .branchCond(branchCond), .memSize(memSize), .signedLoad(signedLoad)
  );

  controlSequencer uSequencer (
    .clk(clk), .rst(rst), .start(start), .waitRequest(waitRequest),
    .aluStall(aluStall), .pcIsZero(pcIsZero), .execCycles(execCycles),
    .state(state), .active(active)
  );

  datapathControl uDatapath (
    .state(state), .instrClass(instrClass), .aluOp(aluOp), .branchDelay(branchDelay),
    .irWrite(irWrite), .irSel(irSel), .pcWrite(pcWrite), .pcSrc(pcSrc),
    .isJump(isJump), .aluSrcA(aluSrcA), .aluSrcB(aluSrcB), .aluControl(aluControl),
    .aluSel(aluSel), .extSel(extSel), .regWrite(regWrite), .regDst(regDst),
    .memToReg(memToReg)
  );

  memoryControl uMemory (
    .state(state), .instrClass(instrClass), .memSize(memSize), .signedLoad(signedLoad),
    .memRead(memRead), .memWrite(memWrite), .iOrD(iOrD), .byteEnable(byteEnable),
    .extendedMem(extendedMem)
  );

  branchResolver uBranch (
    .clk(clk), .rst(rst), .state(state), .branchCond(branchCond),
    .execCycles(execCycles), .aluLsb(aluLsb), .lessThan(lessThan),
    .branchDelay(branchDelay)
  );

endmodule

// File: logic/branchResolver.sv
`timescale 1ns/1ps

module branchResolver import mipsCtrlPkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  state_t      state,
  input  branchCond_t branchCond,
  input  logic [1:0]  execCycles,
  input  logic        aluLsb,
  input  logic        lessThan,
  output logic        branchDelay
);

  logic taken;
  logic lastExec;

  // aluLsb carries the compare result, lessThan the sign of rs
  always_comb begin
    case (branchCond)
      COND_EQ, COND_LEZ: taken = aluLsb;
      COND_NE, COND_GTZ: taken = !aluLsb;
      COND_LTZ:          taken = lessThan;
      COND_GEZ:          taken = !lessThan;
      COND_ALWAYS:       taken = 1'b1;
      default:           taken = 1'b0;
    endcase
  end

  assign lastExec = (state == EXEC1 && execCycles == 2'd1) ||
                    (state == EXEC2 && execCycles == 2'd2) ||
                    (state == EXEC3 && execCycles == 2'd3);

  // FETCH never repeats, so clearing here consumes the flag once
  always_ff @(posedge clk) begin
    if (rst) begin
      branchDelay <= 1'b0;
    end else if (state == FETCH) begin
      branchDelay <= 1'b0;
    end else if (lastExec) begin
      branchDelay <= taken;
    end
  end

endmodule

// File: logic/memoryControl.sv
`timescale 1ns/1ps
`include "mipsCtrl_macros.svh"

module memoryControl import mipsCtrlPkg::*; (
  input  state_t                    state,
  input  instrClass_t               instrClass,
  input  memSize_t                  memSize,
  input  logic                      signedLoad,
  output logic                      memRead,
  output logic                      memWrite,
  output logic                      iOrD,
  output logic [`MIPS_BYTEEN_W-1:0] byteEnable,
  output logic [1:0]                extendedMem
);

  logic isLoad;
  logic isStore;
  logic loadData;

  assign isLoad  = (instrClass == CLS_LOAD);
  assign isStore = (instrClass == CLS_STORE);
  // Read cycle and write-back cycle of a load
  assign loadData = isLoad && (state == EXEC2 || state == EXEC3);

  assign memRead  = (state == FETCH) || (state == STALL) || (isLoad && state == EXEC2);
  assign memWrite = isStore && (state == EXEC2);
  assign iOrD     = (isLoad || isStore) && (state == EXEC2);

  always_comb begin
    byteEnable  = 4'hF;
    extendedMem = 2'b00;
    if (loadData) begin
      case (memSize)
        MEM_HALF: begin
          byteEnable  = 4'h3;
          extendedMem = signedLoad ? 2'b11 : 2'b00;
        end
        MEM_BYTE: begin
          byteEnable  = 4'h1;
          extendedMem = signedLoad ? 2'b10 : 2'b00;
        end
        default: byteEnable = 4'hF;
      endcase
    end
  end

endmodule

// File: logic/datapathControl.sv
`timescale 1ns/1ps

module datapathControl import mipsCtrlPkg::*; (
  input  state_t      state,
  input  instrClass_t instrClass,
  input  aluOp_t      aluOp,
  input  logic        branchDelay,
  output logic        irWrite,
  output logic        irSel,
  output logic        pcWrite,
  output logic        pcSrc,
  output logic        isJump,
  output logic        aluSrcA,
  output logic [1:0]  aluSrcB,
  output aluOp_t      aluControl,
  output logic        aluSel,
  output logic        extSel,
  output logic        regWrite,
  output logic        regDst,
  output logic        memToReg
);

  logic isJumpClass;

  assign isJumpClass = (instrClass == CLS_J) || (instrClass == CLS_JAL);

  always_comb begin
    irWrite    = 1'b0;
    irSel      = 1'b1;
    pcWrite    = 1'b0;
    pcSrc      = 1'b0;
    isJump     = 1'b0;
    aluSrcA    = 1'b0;
    aluSrcB    = 2'b00;
    aluControl = ALU_AND;
    aluSel     = 1'b0;
    extSel     = 1'b0;
    regWrite   = 1'b0;
    regDst     = 1'b0;
    memToReg   = 1'b0;
    case (state)
      FETCH: begin
        pcWrite = 1'b1;
        // Taken branch loads the held target, otherwise PC + 4
        if (branchDelay) begin
          pcSrc = 1'b1;
        end else begin
          aluSrcB    = 2'b01;
          aluControl = ALU_ADD;
        end
      end
      DECODE: begin
        irWrite = 1'b1;
        irSel   = 1'b0;
        aluSrcB = 2'b11;
        if (isJumpClass) begin
          aluControl = ALU_PASSB;
          extSel     = 1'b1;
        end else begin
          // Precompute the branch target while registers are read
          aluControl = ALU_BRTARGET;
        end
      end
      EXEC1: begin
        case (instrClass)
          CLS_RALU, CLS_BRANCH: begin
            aluSrcA    = 1'b1;
            aluControl = aluOp;
          end
          CLS_IMM, CLS_LUI, CLS_LOAD, CLS_STORE: begin
            aluSrcA    = 1'b1;
            aluSrcB    = 2'b10;
            aluControl = aluOp;
            // Logical immediates are zero extended
            extSel = (instrClass == CLS_IMM) &&
                     (aluOp == ALU_AND || aluOp == ALU_OR || aluOp == ALU_XOR);
          end
          CLS_JR: begin
            aluSrcA    = 1'b1;
            aluControl = ALU_PASSA;
            isJump     = 1'b1;
          end
          CLS_J: begin
            aluSrcB    = 2'b11;
            aluControl = ALU_JTARGET;
            extSel     = 1'b1;
            isJump     = 1'b1;
          end
          CLS_JAL: begin
            // Link address PC + 4 goes to the register file
            aluSrcB    = 2'b01;
            aluControl = ALU_ADD;
            regWrite   = 1'b1;
            memToReg   = 1'b1;
          end
          default: ;
        endcase
      end
      EXEC2: begin
        case (instrClass)
          CLS_RALU, CLS_IMM, CLS_LUI: begin
            aluSel   = 1'b1;
            memToReg = 1'b1;
            regWrite = 1'b1;
            regDst   = (instrClass == CLS_RALU);
          end
          CLS_JAL: begin
            aluSrcB    = 2'b11;
            aluControl = ALU_JTARGET;
            extSel     = 1'b1;
            isJump     = 1'b1;
          end
          CLS_LOAD: aluSel = 1'b1;
          default: ;
        endcase
      end
      EXEC3: regWrite = (instrClass == CLS_LOAD);
      default: ;
    endcase
  end

endmodule

// File: logic/controlSequencer.sv
`timescale 1ns/1ps

module controlSequencer import mipsCtrlPkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       start,
  input  logic       waitRequest,
  input  logic       aluStall,
  input  logic       pcIsZero,
  input  logic [1:0] execCycles,
  output state_t     state,
  output logic       active
);

  state_t nextState;

  always_comb begin
    nextState = state;
    case (state)
      HALTED: begin
        if (start) begin
          nextState = FETCH;
        end
      end
      // Instruction fetch waits out a busy memory in STALL
      FETCH, STALL: nextState = waitRequest ? STALL : DECODE;
      DECODE: nextState = EXEC1;
      EXEC1: begin
        if (!aluStall) begin
          nextState = (execCycles > 2'd1) ? EXEC2 : FETCH;
        end
      end
      EXEC2: begin
        if (!waitRequest) begin
          nextState = (execCycles == 2'd3) ? EXEC3 : FETCH;
        end
      end
      EXEC3: nextState = FETCH;
      default: nextState = HALTED;
    endcase
    // Return to PC zero ends the program
    if (pcIsZero && state != HALTED) begin
      nextState = HALTED;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= HALTED;
    end else begin
      state <= nextState;
    end
  end

  assign active = (state != HALTED);

endmodule

// File: logic/instrClassifier.sv
`timescale 1ns/1ps
`include "mipsCtrl_macros.svh"

module instrClassifier import mipsCtrlPkg::*; (
  input  logic [`MIPS_INSTR_W-1:0] instr,
  output instrClass_t              instrClass,
  output logic [1:0]               execCycles,
  output aluOp_t                   aluOp,
  output branchCond_t              branchCond,
  output memSize_t                 memSize,
  output logic                     signedLoad
);

  opcode_t opcode;
  funct_t  funct;
  regimm_t rtCode;

  assign opcode = opcode_t'(instr[31:26]);
  assign funct  = funct_t'(instr[`MIPS_FUNCT_W-1:0]);
  assign rtCode = regimm_t'(instr[20:16]);

  always_comb begin
    instrClass = CLS_NOP;
    aluOp      = ALU_ADD;
    branchCond = COND_NONE;
    memSize    = MEM_WORD;
    signedLoad = 1'b0;
    case (opcode)
      OP_RTYPE: begin
        if (funct == FN_JR) begin
          instrClass = CLS_JR;
          branchCond = COND_ALWAYS;
        end else begin
          instrClass = CLS_RALU;
          aluOp      = ALU_RFUNCT;
        end
      end
      OP_ADDIU: instrClass = CLS_IMM;
      OP_ANDI:  begin instrClass = CLS_IMM; aluOp = ALU_AND; end
      OP_ORI:   begin instrClass = CLS_IMM; aluOp = ALU_OR;  end
      OP_XORI:  begin instrClass = CLS_IMM; aluOp = ALU_XOR; end
      OP_SLTI:  begin instrClass = CLS_IMM; aluOp = ALU_SLT; end
      OP_LUI:   begin instrClass = CLS_LUI; aluOp = ALU_LUI; end
      // Address is base plus offset for every access
      OP_LW:  instrClass = CLS_LOAD;
      OP_LH:  begin instrClass = CLS_LOAD; memSize = MEM_HALF; signedLoad = 1'b1; end
      OP_LHU: begin instrClass = CLS_LOAD; memSize = MEM_HALF; end
      OP_LB:  begin instrClass = CLS_LOAD; memSize = MEM_BYTE; signedLoad = 1'b1; end
      OP_LBU: begin instrClass = CLS_LOAD; memSize = MEM_BYTE; end
      OP_SW:  instrClass = CLS_STORE;
      OP_BEQ:  begin instrClass = CLS_BRANCH; aluOp = ALU_CMPEQ;  branchCond = COND_EQ;  end
      OP_BNE:  begin instrClass = CLS_BRANCH; aluOp = ALU_CMPEQ;  branchCond = COND_NE;  end
      OP_BLEZ: begin instrClass = CLS_BRANCH; aluOp = ALU_CMPLEZ; branchCond = COND_LEZ; end
      OP_BGTZ: begin instrClass = CLS_BRANCH; aluOp = ALU_CMPLEZ; branchCond = COND_GTZ; end
      OP_REGIMM: begin
        // Only the plain sign tests, linking forms fall through as NOP
        if (rtCode == RT_BLTZ || rtCode == RT_BGEZ) begin
          instrClass = CLS_BRANCH;
          aluOp      = ALU_SIGN;
          branchCond = (rtCode == RT_BLTZ) ? COND_LTZ : COND_GEZ;
        end
      end
      OP_J:   begin instrClass = CLS_J;   branchCond = COND_ALWAYS; end
      OP_JAL: begin instrClass = CLS_JAL; branchCond = COND_ALWAYS; end
      default: instrClass = CLS_NOP;
    endcase
  end

  always_comb begin
    case (instrClass)
      CLS_RALU, CLS_IMM, CLS_LUI, CLS_STORE, CLS_JAL: execCycles = 2'd2;
      CLS_LOAD: execCycles = 2'd3;
      default:  execCycles = 2'd1;
    endcase
  end

endmodule

// File: logic/mipsCtrlPkg.sv
`include "mipsCtrl_macros.svh"

package mipsCtrlPkg;

  // Primary opcodes, bits 31:26
  typedef enum logic [`MIPS_OPCODE_W-1:0] {
    OP_RTYPE  = 6'b000000,
    OP_REGIMM = 6'b000001,
    OP_J      = 6'b000010,
    OP_JAL    = 6'b000011,
    OP_BEQ    = 6'b000100,
    OP_BNE    = 6'b000101,
    OP_BLEZ   = 6'b000110,
    OP_BGTZ   = 6'b000111,
    OP_ADDIU  = 6'b001001,
    OP_SLTI   = 6'b001010,
    OP_ANDI   = 6'b001100,
    OP_ORI    = 6'b001101,
    OP_XORI   = 6'b001110,
    OP_LUI    = 6'b001111,
    OP_LB     = 6'b100000,
    OP_LH     = 6'b100001,
    OP_LW     = 6'b100011,
    OP_LBU    = 6'b100100,
    OP_LHU    = 6'b100101,
    OP_SW     = 6'b101011
  } opcode_t;

  // R-type function field, bits 5:0
  typedef enum logic [`MIPS_FUNCT_W-1:0] {
    FN_JR   = 6'b001000,
    FN_ADDU = 6'b100001,
    FN_AND  = 6'b100100,
    FN_OR   = 6'b100101
  } funct_t;

  // REGIMM branches select on the rt field
  typedef enum logic [`MIPS_RT_W-1:0] {
    RT_BLTZ = 5'b00000,
    RT_BGEZ = 5'b00001
  } regimm_t;

  typedef enum logic [`MIPS_STATE_W-1:0] {
    FETCH  = 3'd0,
    DECODE = 3'd1,
    EXEC1  = 3'd2,
    EXEC2  = 3'd3,
    EXEC3  = 3'd4,
    HALTED = 3'd5,
    STALL  = 3'd6
  } state_t;

  // Codes understood by the datapath ALU
  typedef enum logic [`MIPS_ALUCTRL_W-1:0] {
    ALU_AND      = 5'b00000,
    ALU_OR       = 5'b00001,
    ALU_ADD      = 5'b00010,
    ALU_XOR      = 5'b00011,
    ALU_SLT      = 5'b00111,
    ALU_CMPEQ    = 5'b01010,
    ALU_PASSB    = 5'b01011,
    ALU_SIGN     = 5'b01100,
    ALU_BRTARGET = 5'b01101,
    ALU_PASSA    = 5'b01110,
    ALU_RFUNCT   = 5'b01111,
    ALU_CMPLEZ   = 5'b10000,
    ALU_JTARGET  = 5'b10001,
    ALU_LUI      = 5'b10100
  } aluOp_t;

  typedef enum logic [3:0] {
    CLS_RALU, CLS_JR, CLS_IMM, CLS_LUI, CLS_LOAD,
    CLS_STORE, CLS_BRANCH, CLS_J, CLS_JAL, CLS_NOP
  } instrClass_t;

  typedef enum logic [2:0] {
    COND_NONE, COND_EQ, COND_NE, COND_LEZ,
    COND_GTZ, COND_LTZ, COND_GEZ, COND_ALWAYS
  } branchCond_t;

  typedef enum logic [1:0] {
    MEM_WORD, MEM_HALF, MEM_BYTE
  } memSize_t;

endpackage

// File: include/mipsCtrl_macros.svh
`ifndef MIPS_CTRL_MACROS_SVH
`define MIPS_CTRL_MACROS_SVH

// Instruction word and field widths
`define MIPS_INSTR_W 32
`define MIPS_OPCODE_W 6
`define MIPS_FUNCT_W 6
`define MIPS_RT_W 5

// ALU operation code driven to the datapath
`define MIPS_ALUCTRL_W 5

// One enable per byte lane of the memory word
`define MIPS_BYTEEN_W 4

// Sequencer state code
`define MIPS_STATE_W 3

`endif
